// ==== source/soc_mem_config.svh ====
`ifndef SOC_MEM_CONFIG_SVH
`define SOC_MEM_CONFIG_SVH

// Width of one data word
`define SOC_DATA_W 32

// Word address width, 256 words of external memory
`define SOC_ADDR_W 8

// Bus masters sharing the memory, system and tester
`define SOC_N_MASTERS 2

// Cycles from external reset release to the start of the pulse
`define SOC_RST_START 5

// Length of the system reset pulse in cycles
`define SOC_RST_DURATION 10

`endif

// ==== source/soc_mem_pkg.sv ====
`include "soc_mem_config.svh"

package soc_mem_pkg;

   // Word address into external memory
   typedef logic [`SOC_ADDR_W-1:0] mem_addr_t;

   // One data word
   typedef logic [`SOC_DATA_W-1:0] mem_data_t;

   // Index of a bus master
   typedef logic [$clog2(`SOC_N_MASTERS)-1:0] master_idx_t;

endpackage

// ==== source/mem_req_if.sv ====
`include "soc_mem_config.svh"

interface mem_req_if;

   // Request side, held steady while req_valid is high
   logic                   req_valid;
   logic                   req_we;
   logic [`SOC_ADDR_W-1:0] req_addr;
   logic [`SOC_DATA_W-1:0] req_wdata;

   // Request is consumed in the grant cycle
   logic                   grant;

   // One pulse per read, none for a write
   logic                   rsp_valid;
   logic [`SOC_DATA_W-1:0] rsp_rdata;

   modport port (
      output req_valid, req_we, req_addr, req_wdata,
      input  grant, rsp_valid, rsp_rdata
   );

   modport arbiter (
      input  req_valid, req_we, req_addr, req_wdata,
      output grant, rsp_valid, rsp_rdata
   );

endinterface

// ==== source/reset_pulse_gen.sv ====
`include "soc_mem_config.svh"

module reset_pulse_gen
   import soc_mem_pkg::*;
(
   input  logic clk_i,
   input  logic rst_i,
   output logic sys_rst_o
);

   localparam int unsigned TOTAL = `SOC_RST_START + `SOC_RST_DURATION;
   // Sync stage, compare on the old count and the port state register
   // take up the remaining three cycles of the total
   localparam int unsigned LAST_CNT = TOTAL - 3;
   localparam int unsigned CNT_W = $clog2(LAST_CNT + 1);

   logic             start_q;
   logic [CNT_W-1:0] cnt_q;

   // Start sync on release of the external reset
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         start_q <= 1'b0;
      end else begin
         start_q <= 1'b1;
      end
   end

   // One counter covers the start delay and the pulse length
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cnt_q     <= '0;
         sys_rst_o <= 1'b1;
      end else if (start_q && sys_rst_o) begin
         cnt_q <= cnt_q + 1'b1;
         if (cnt_q == CNT_W'(LAST_CNT)) begin
            sys_rst_o <= 1'b0;
         end
      end
   end

   // Once low, the output stays low until the next rst_i

endmodule

// ==== source/ext_mem.sv ====
module ext_mem
   import soc_mem_pkg::*;
(
   input  logic      clk_i,
   input  logic      en_i,
   input  logic      we_i,
   input  mem_addr_t addr_i,
   input  mem_data_t wdata_i,
   output mem_data_t rdata_o
);

   localparam int unsigned DEPTH = 2 ** $bits(mem_addr_t);

   // Stand-in for the external DDR
   mem_data_t mem_q [DEPTH];

   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i) begin
            mem_q[addr_i] <= wdata_i;
         end else begin
            // Registered read, held across writes
            rdata_o <= mem_q[addr_i];
         end
      end
   end

endmodule

// ==== source/mem_port.sv ====
module mem_port
   import soc_mem_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,

   // Master side
   input  logic      req_valid_i,
   input  logic      req_we_i,
   input  mem_addr_t req_addr_i,
   input  mem_data_t req_wdata_i,
   output logic      req_ready_o,
   output logic      rsp_valid_o,
   output mem_data_t rsp_rdata_o,

   // Arbiter side
   mem_req_if.port   bus
);

   typedef enum logic [1:0] {
      ST_OFF,
      ST_IDLE,
      ST_REQ,
      ST_RSP
   } port_state_t;

   port_state_t state_q;

   logic      we_q;
   mem_addr_t addr_q;
   mem_data_t wdata_q;

   logic      accept;

   assign req_ready_o = (state_q == ST_IDLE);
   assign accept      = req_ready_o && req_valid_i;

   // Busy from acceptance until write grant or read response
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_OFF;
      end else begin
         case (state_q)
            ST_OFF: state_q <= ST_IDLE;
            ST_IDLE: begin
               if (req_valid_i) begin
                  state_q <= ST_REQ;
               end
            end
            ST_REQ: begin
               if (bus.grant) begin
                  state_q <= we_q ? ST_IDLE : ST_RSP;
               end
            end
            ST_RSP: begin
               if (bus.rsp_valid) begin
                  state_q <= ST_IDLE;
               end
            end
            default: state_q <= ST_OFF;
         endcase
      end
   end

   // One-entry request buffer
   always_ff @(posedge clk_i) begin
      if (accept) begin
         we_q    <= req_we_i;
         addr_q  <= req_addr_i;
         wdata_q <= req_wdata_i;
      end
   end

   assign bus.req_valid = (state_q == ST_REQ);
   assign bus.req_we    = we_q;
   assign bus.req_addr  = addr_q;
   assign bus.req_wdata = wdata_q;

   // Response goes straight back to the master
   assign rsp_valid_o = bus.rsp_valid;
   assign rsp_rdata_o = bus.rsp_rdata;

endmodule

// ==== source/mem_arbiter.sv ====
`include "soc_mem_config.svh"

module mem_arbiter
   import soc_mem_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   mem_req_if.arbiter  ports [`SOC_N_MASTERS]
);

   localparam int N = `SOC_N_MASTERS;

   logic [N-1:0] req_valid;
   logic [N-1:0] req_we;
   mem_addr_t    req_addr  [N];
   mem_data_t    req_wdata [N];
   logic [N-1:0] grant;

   logic         found;
   master_idx_t  win_idx;
   master_idx_t  last_q;

   // Memory command
   logic         mem_we;
   mem_addr_t    mem_addr;
   mem_data_t    mem_wdata;
   mem_data_t    mem_rdata;

   // Response pipeline
   logic         s1_read_q;
   master_idx_t  s1_idx_q;
   logic         s2_read_q;
   master_idx_t  s2_idx_q;
   mem_data_t    s2_rdata_q;

   for (genvar i = 0; i < N; i++) begin : g_ports
      assign req_valid[i]       = ports[i].req_valid;
      assign req_we[i]          = ports[i].req_we;
      assign req_addr[i]        = ports[i].req_addr;
      assign req_wdata[i]       = ports[i].req_wdata;
      assign ports[i].grant     = grant[i];
      // Only the winner of this read sees the pulse
      assign ports[i].rsp_valid = s2_read_q && (s2_idx_q == master_idx_t'(i));
      assign ports[i].rsp_rdata = s2_rdata_q;
   end

   // Round robin, search starts one past the last winner
   always_comb begin
      master_idx_t cand;
      found   = 1'b0;
      win_idx = last_q;
      grant   = '0;
      for (int off = 1; off <= N; off++) begin
         cand = master_idx_t'((int'(last_q) + off) % N);
         if (!found && req_valid[cand]) begin
            found   = 1'b1;
            win_idx = cand;
         end
      end
      if (found) begin
         grant[win_idx] = 1'b1;
      end
   end

   assign mem_we    = req_we[win_idx];
   assign mem_addr  = req_addr[win_idx];
   assign mem_wdata = req_wdata[win_idx];

   ext_mem mem0 (
      .clk_i   (clk_i),
      .en_i    (found),
      .we_i    (mem_we),
      .addr_i  (mem_addr),
      .wdata_i (mem_wdata),
      .rdata_o (mem_rdata)
   );

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         last_q    <= master_idx_t'(N - 1);
         s1_read_q <= 1'b0;
         s2_read_q <= 1'b0;
      end else begin
         if (found) begin
            last_q <= win_idx;
         end
         s1_read_q <= found && !mem_we;
         s2_read_q <= s1_read_q;
      end
   end

   // Winner index and read data follow the read flag
   always_ff @(posedge clk_i) begin
      s1_idx_q   <= win_idx;
      s2_idx_q   <= s1_idx_q;
      s2_rdata_q <= mem_rdata;
   end

endmodule

// ==== source/soc_mem_top.sv ====
`include "soc_mem_config.svh"

module soc_mem_top
   import soc_mem_pkg::*;
(
   input  logic                                 clk_i,
   input  logic                                 rst_i,

   // Per-master request
   input  logic      [`SOC_N_MASTERS-1:0]       req_valid_i,
   input  logic      [`SOC_N_MASTERS-1:0]       req_we_i,
   input  mem_addr_t [`SOC_N_MASTERS-1:0]       req_addr_i,
   input  mem_data_t [`SOC_N_MASTERS-1:0]       req_wdata_i,
   output logic      [`SOC_N_MASTERS-1:0]       req_ready_o,

   // Per-master response
   output logic      [`SOC_N_MASTERS-1:0]       rsp_valid_o,
   output mem_data_t [`SOC_N_MASTERS-1:0]       rsp_rdata_o,

   // Trap from system and tester
   input  logic      [`SOC_N_MASTERS-1:0]       trap_i,
   output logic                                 trap_o
);

   logic sys_rst;

   assign trap_o = |trap_i;

   // Board-level reset pulse
   reset_pulse_gen rst_gen0 (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .sys_rst_o (sys_rst)
   );

   mem_req_if bus_if [`SOC_N_MASTERS] ();

   for (genvar i = 0; i < `SOC_N_MASTERS; i++) begin : g_port
      mem_port port0 (
         .clk_i       (clk_i),
         .rst_i       (sys_rst),
         .req_valid_i (req_valid_i[i]),
         .req_we_i    (req_we_i[i]),
         .req_addr_i  (req_addr_i[i]),
         .req_wdata_i (req_wdata_i[i]),
         .req_ready_o (req_ready_o[i]),
         .rsp_valid_o (rsp_valid_o[i]),
         .rsp_rdata_o (rsp_rdata_o[i]),
         .bus         (bus_if[i])
      );
   end

   // Shared memory behind the round-robin arbiter
   mem_arbiter arb0 (
      .clk_i (clk_i),
      .rst_i (sys_rst),
      .ports (bus_if)
   );

endmodule

// ==== bench/soc_mem_properties.sv ====
`include "soc_mem_config.svh"

module soc_mem_properties
   import soc_mem_pkg::*;
(
   input logic                      clk_i,
   input logic                      rst_i,
   input logic [`SOC_N_MASTERS-1:0] req_valid_i,
   input logic [`SOC_N_MASTERS-1:0] req_we_i,
   input logic [`SOC_N_MASTERS-1:0] grant_i,
   input logic                      s2_read_i,
   input master_idx_t               s2_idx_i
);

   logic [`SOC_N_MASTERS-1:0] read_grant;
   logic [`SOC_N_MASTERS-1:0] rsp_port;

   // Ports granted a read in this cycle
   assign read_grant = grant_i & ~req_we_i;

   // Port addressed by the response stage
   always_comb begin
      rsp_port = '0;
      if (s2_read_i) begin
         rsp_port[s2_idx_i] = 1'b1;
      end
   end

   // Never more than one winner
   one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(grant_i))
      else $error("arbiter granted more than one port: %b", grant_i);

   // Response reaches the granted port two cycles after a read grant
   read_latency: assert property (@(posedge clk_i) disable iff (rst_i)
      rsp_port == $past(read_grant, 2))
      else $error("read response not on the granted port two cycles after its grant");

   // Grant only where a request is pending
   grant_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
      (grant_i & ~req_valid_i) == '0)
      else $error("grant to a port without a request: grant %b valid %b",
                  grant_i, req_valid_i);

endmodule

bind mem_arbiter soc_mem_properties props0 (
   .clk_i       (clk_i),
   .rst_i       (rst_i),
   .req_valid_i (req_valid),
   .req_we_i    (req_we),
   .grant_i     (grant),
   .s2_read_i   (s2_read_q),
   .s2_idx_i    (s2_idx_q)
);

// ==== bench/soc_mem_tb.sv ====
`include "soc_mem_config.svh"

module soc_mem_tb
   import soc_mem_pkg::*;
();

   localparam int N            = `SOC_N_MASTERS;
   localparam int DEPTH        = 1 << `SOC_ADDR_W;
   localparam int HALF         = DEPTH / 2;
   localparam int unsigned SEED = 32'h39a3_a64a;
   localparam int RST_CYC      = `SOC_RST_START + `SOC_RST_DURATION;
   localparam int T2_WORDS     = 32;
   localparam int T3_OPS       = 400;
   localparam int T4_ROUNDS    = 8;

   // Worst-case cycles per request with latency, handshake and idle gap
   localparam int REQ_CYC      = 9;
   localparam int RESET_CYC    = 8 + RST_CYC;
   localparam int REQ_TOTAL    = 2 * T2_WORDS + N * T3_OPS + 3 * T4_ROUNDS + 4;
   localparam int CYCLE_LIMIT  = 4 * (RESET_CYC + REQ_TOTAL * REQ_CYC);

   logic                clk_i;
   logic                rst_i;
   logic      [N-1:0]   req_valid;
   logic      [N-1:0]   req_we;
   mem_addr_t [N-1:0]   req_addr;
   mem_data_t [N-1:0]   req_wdata;
   logic      [N-1:0]   req_ready;
   logic      [N-1:0]   rsp_valid;
   mem_data_t [N-1:0]   rsp_rdata;
   logic      [N-1:0]   trap;
   logic                trap_o;

   // Reference memory and a flag for each written address
   mem_data_t ref_mem [DEPTH];
   logic      written [DEPTH];

   int        reads_done [N];
   int        rsp_count [N];
   int        cycle_cnt;
   string     cur_test;
   int        test_errs;
   int        errors;
   int        checks;
   int        tests_run;
   int        tests_failed;

   soc_mem_top dut0 (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (req_valid),
      .req_we_i    (req_we),
      .req_addr_i  (req_addr),
      .req_wdata_i (req_wdata),
      .req_ready_o (req_ready),
      .rsp_valid_o (rsp_valid),
      .rsp_rdata_o (rsp_rdata),
      .trap_i      (trap),
      .trap_o      (trap_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // Count every response pulse per master
   always @(negedge clk_i) begin
      for (int m = 0; m < N; m++) begin
         if (rsp_valid[m]) begin
            rsp_count[m]++;
         end
      end
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("timeout: run did not end within %0d cycles, in test %s",
               CYCLE_LIMIT, cur_test);
      $display("TB FAILED");
      $finish;
   end

   task automatic compare_word(input string what, input mem_data_t expected,
                               input mem_data_t actual);
      checks++;
      assert (actual === expected) else begin
         $display("FAILED %s %s: expected %h actual %h", cur_test, what, expected, actual);
         test_errs++;
      end
   endtask

   task automatic start_test(input string name);
      @(negedge clk_i);
      cur_test  = name;
      test_errs = 0;
   endtask

   task automatic close_test();
      tests_run++;
      if (test_errs != 0) begin
         tests_failed++;
      end
      errors += test_errs;
      $display("test %s: %0d errors", cur_test, test_errs);
   endtask

   // Starts at a falling edge and returns at the falling edge after acceptance
   task automatic send_request(input int m, input logic we, input mem_addr_t a,
                               input mem_data_t d);
      req_valid[m] = 1'b1;
      req_we[m]    = we;
      req_addr[m]  = a;
      req_wdata[m] = d;
      while (!req_ready[m]) begin
         @(negedge clk_i);
      end
      @(negedge clk_i);
      req_valid[m] = 1'b0;
   endtask

   task automatic write_word(input int m, input mem_addr_t a, input mem_data_t d);
      send_request(m, 1'b1, a, d);
      ref_mem[a] = d;
      written[a] = 1'b1;
   endtask

   task automatic read_word(input int m, input mem_addr_t a);
      mem_data_t expected;
      expected = ref_mem[a];
      send_request(m, 1'b0, a, '0);
      while (!rsp_valid[m]) begin
         @(negedge clk_i);
      end
      compare_word($sformatf("m%0d read %h", m, a), expected, rsp_rdata[m]);
      reads_done[m]++;
   endtask

   // Random reads and writes within the master's own address half
   task automatic run_traffic(input int m, input int count);
      mem_addr_t a;
      logic      we;
      for (int k = 0; k < count; k++) begin
         a  = mem_addr_t'(m * HALF + $urandom_range(0, HALF - 1));
         we = $urandom_range(0, 1) == 1;
         if (!written[a]) begin
            we = 1'b1;
         end
         if (we) begin
            write_word(m, a, $urandom());
         end else begin
            read_word(m, a);
         end
         repeat ($urandom_range(0, 3)) @(negedge clk_i);
      end
   endtask

   initial begin
      mem_addr_t t2_addr [T2_WORDS];
      mem_addr_t a;
      int        base_reads [N];
      int        base_rsp [N];

      rst_i     = 1'b1;
      req_valid = '0;
      req_we    = '0;
      req_addr  = '0;
      req_wdata = '0;
      trap      = '0;
      errors    = 0;
      checks    = 0;
      tests_run = 0;
      tests_failed = 0;
      test_errs = 0;
      cur_test  = "init";
      for (int i = 0; i < DEPTH; i++) begin
         written[i] = 1'b0;
      end
      for (int m = 0; m < N; m++) begin
         reads_done[m] = 0;
         rsp_count[m]  = 0;
      end
      void'($urandom(SEED));

      // Test 1 covers the release of the board reset pulse
      start_test("reset pulse");
      for (int c = 2; c <= 8; c++) begin
         @(negedge clk_i);
         compare_word("ready in reset", '0, mem_data_t'(req_ready));
         compare_word("response in reset", '0, mem_data_t'(rsp_valid));
      end
      rst_i = 1'b0;
      for (int c = 1; c < RST_CYC; c++) begin
         @(negedge clk_i);
         compare_word($sformatf("ready %0d cycles after reset", c), '0,
                      mem_data_t'(req_ready));
         compare_word("response in pulse", '0, mem_data_t'(rsp_valid));
      end
      @(negedge clk_i);
      compare_word("ready after pulse", mem_data_t'(2 ** N - 1), mem_data_t'(req_ready));
      close_test();

      // Test 2 has one master write and then read back
      start_test("single master");
      for (int k = 0; k < T2_WORDS; k++) begin
         t2_addr[k] = mem_addr_t'($urandom_range(0, HALF - 1));
         write_word(0, t2_addr[k], $urandom());
      end
      for (int k = 0; k < T2_WORDS; k++) begin
         read_word(0, t2_addr[k]);
      end
      close_test();

      // Test 3 runs both masters in parallel
      start_test("concurrent traffic");
      for (int m = 0; m < N; m++) begin
         base_reads[m] = reads_done[m];
         base_rsp[m]   = rsp_count[m];
      end
      fork
         run_traffic(0, T3_OPS);
         run_traffic(1, T3_OPS);
      join
      @(negedge clk_i);
      for (int m = 0; m < N; m++) begin
         compare_word($sformatf("m%0d response count", m),
                      mem_data_t'(reads_done[m] - base_reads[m]),
                      mem_data_t'(rsp_count[m] - base_rsp[m]));
      end
      close_test();

      // Test 4 checks a write from master 1 seen by both masters
      start_test("shared address");
      for (int r = 0; r < T4_ROUNDS; r++) begin
         a = mem_addr_t'($urandom_range(0, DEPTH - 1));
         write_word(1, a, $urandom());
         while (!req_ready[1]) begin
            @(negedge clk_i);
         end
         fork
            read_word(0, a);
            read_word(1, a);
         join
      end
      close_test();

      // Test 5 checks the combined trap
      start_test("trap");
      for (int v = 0; v < 2 ** N; v++) begin
         trap = N'(v);
         @(posedge clk_i);
         compare_word($sformatf("trap %b", trap), mem_data_t'(v != 0), mem_data_t'(trap_o));
         @(negedge clk_i);
      end
      trap = '0;
      close_test();

      @(negedge clk_i);
      $display("tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+source
source/soc_mem_pkg.sv
source/mem_req_if.sv
source/reset_pulse_gen.sv
source/ext_mem.sv
source/mem_port.sv
source/mem_arbiter.sv
source/soc_mem_top.sv
bench/soc_mem_properties.sv
bench/soc_mem_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := soc_mem_tb
FILELIST   := project.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
